//--- hw/core_pkg.sv
// shared encodings for the microcoded 16-bit core
// MOVI, LD and ST carry their register in opcode bits 1..0
// every microcode sequence is a single step for now
package core_pkg;

  localparam int MICRO_ADDR_W = 5;
  localparam int NREGS        = 4;
  localparam int REG_W        = $clog2(NREGS);

  typedef enum logic [7:0] {
    OP_ADD  = 8'h01,
    OP_SUB  = 8'h29,
    OP_JNZ  = 8'h75,
    OP_LD   = 8'hA0,
    OP_ST   = 8'hA4,
    OP_MOVI = 8'hB0,
    OP_HLT  = 8'hF4,
    OP_CLI  = 8'hFA,
    OP_STI  = 8'hFB
  } opcode_e;

  typedef enum logic [3:0] {
    UOP_PASS,
    UOP_ADD,
    UOP_SUB,
    UOP_LOAD,
    UOP_STORE,
    UOP_JNZ,
    UOP_STI,
    UOP_CLI,
    UOP_HLT,
    UOP_NOP
  } micro_op_e;

  // register select: opcode field, modrm bits 3..0, modrm bits 7..4
  localparam logic [1:0] SEL_OPC = 2'd0;
  localparam logic [1:0] SEL_DST = 2'd1;
  localparam logic [1:0] SEL_SRC = 2'd2;

  // sequence start addresses
  localparam logic [MICRO_ADDR_W-1:0] SEQ_MOVI = 5'd0;
  localparam logic [MICRO_ADDR_W-1:0] SEQ_ADD  = 5'd1;
  localparam logic [MICRO_ADDR_W-1:0] SEQ_SUB  = 5'd2;
  localparam logic [MICRO_ADDR_W-1:0] SEQ_LD   = 5'd3;
  localparam logic [MICRO_ADDR_W-1:0] SEQ_ST   = 5'd4;
  localparam logic [MICRO_ADDR_W-1:0] SEQ_JNZ  = 5'd5;
  localparam logic [MICRO_ADDR_W-1:0] SEQ_STI  = 5'd6;
  localparam logic [MICRO_ADDR_W-1:0] SEQ_CLI  = 5'd7;
  localparam logic [MICRO_ADDR_W-1:0] SEQ_HLT  = 5'd8;
  localparam logic [MICRO_ADDR_W-1:0] SEQ_NOP  = 5'd9;

  typedef struct packed {
    micro_op_e  op;
    logic [1:0] dst_sel;
    logic [1:0] src_sel;
    logic       use_imm;
    logic       mem_rd;
    logic       mem_wr;
    logic       end_seq;
    logic [3:0] next;
  } micro_word_t;

  typedef struct packed {
    logic zf;
    logic ifl;
  } flags_t;

endpackage

//--- hw/fetch_if.sv
// instruction hand-off from fetch to decode
// need_imm and need_byte2 are decoded from opcode and flow back to fetch
`timescale 1ns/1ns

interface fetch_if;
  logic        valid;
  logic        ready;
  logic [7:0]  opcode;
  logic [7:0]  modrm;
  logic [15:0] imm;
  logic        need_imm;
  logic        need_byte2;

  modport fetch (
    output valid, opcode, modrm, imm,
    input  ready, need_imm, need_byte2
  );

  modport decode (
    input  valid, opcode, modrm, imm,
    output ready, need_imm, need_byte2
  );
endinterface

//--- hw/core_fetch.sv
// byte-serial instruction fetch, one bus transfer per byte
// interrupts are taken only when decode is idle and no byte read is in flight
// a jump or interrupt discards any partly or fully fetched instruction
`timescale 1ns/1ns

module core_fetch #(
  parameter logic [19:0] INT_VECTOR = 20'h00100
) (
  input  logic        clk,
  input  logic        rst,
  fetch_if.fetch      fi,
  output logic        bus_req_o,
  output logic [19:0] bus_addr_o,
  input  logic        bus_ready_i,
  input  logic [7:0]  bus_byte_i,
  input  logic        bus_blocked_i,
  input  logic        jump_i,
  input  logic [19:0] jump_target_i,
  input  logic        intr_i,
  input  logic        ifl_i,
  input  logic        boundary_i,
  output logic        int_taken_o,
  output logic [19:0] pc_o
);

  logic [19:0] pc_q;
  logic [1:0]  cnt_q;
  logic        run_q;
  logic [7:0]  opcode_q;
  logic [7:0]  modrm_q;
  logic [15:0] imm_q;
  logic        complete;
  logic        byte_done;
  logic        take_int;

  // instruction length known once the opcode byte is in
  always_comb begin
    case (cnt_q)
      2'd1:    complete = !fi.need_imm && !fi.need_byte2;
      2'd2:    complete = fi.need_byte2;
      2'd3:    complete = 1'b1;
      default: complete = 1'b0;
    endcase
  end

  assign bus_req_o  = run_q && !complete && !bus_blocked_i;
  assign bus_addr_o = pc_q;
  assign byte_done  = bus_req_o && bus_ready_i;

  // wait for an open byte read to finish before redirecting
  assign take_int    = intr_i && ifl_i && boundary_i && (!bus_req_o || bus_ready_i);
  assign int_taken_o = take_int;

  assign fi.valid  = complete && !take_int;
  assign fi.opcode = opcode_q;
  assign fi.modrm  = modrm_q;
  assign fi.imm    = imm_q;
  assign pc_o      = pc_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      pc_q  <= '0;
      cnt_q <= '0;
      run_q <= 1'b0;
    end else begin
      run_q <= 1'b1;
      if (take_int) begin
        pc_q  <= INT_VECTOR;
        cnt_q <= '0;
      end else if (jump_i) begin
        pc_q  <= jump_target_i;
        cnt_q <= '0;
      end else if (fi.valid && fi.ready) begin
        cnt_q <= '0;
      end else if (byte_done) begin
        pc_q  <= pc_q + 20'd1;
        cnt_q <= cnt_q + 2'd1;
      end
    end
  end

  // byte assembly, immediate is little endian
  always_ff @(posedge clk) begin
    if (byte_done) begin
      case (cnt_q)
        2'd0: opcode_q <= bus_byte_i;
        2'd1: begin
          if (fi.need_byte2)
            modrm_q <= bus_byte_i;
          else
            imm_q[7:0] <= bus_byte_i;
        end
        default: imm_q[15:8] <= bus_byte_i;
      endcase
    end
  end

endmodule

//--- hw/core_decode.sv
// opcode to microcode sequence, holds the instruction while it executes
// unknown opcodes run a single no-op step
`timescale 1ns/1ns

module core_decode
  import core_pkg::*;
(
  input  logic                    clk,
  input  logic                    rst,
  fetch_if.decode                 fi,
  input  logic                    ex_done_i,
  input  micro_word_t             word_i,
  output logic [MICRO_ADDR_W-1:0] seq_addr_o,
  output logic                    ex_valid_o,
  output logic [15:0]             imm_o,
  output logic [7:0]              modrm_o,
  output logic [REG_W-1:0]        reg_o,
  output logic                    boundary_o
);

  logic                    live_q;
  logic [MICRO_ADDR_W-1:0] addr_q;
  logic [MICRO_ADDR_W-1:0] start;
  logic [15:0]             imm_q;
  logic [7:0]              modrm_q;
  logic [REG_W-1:0]        reg_q;
  logic                    accept;

  function automatic logic [MICRO_ADDR_W-1:0] start_addr(input logic [7:0] op);
    logic [7:0] base;
    // drop the register field for the reg-in-opcode forms
    base = {op[7:2], 2'b00};
    if (base == OP_MOVI) return SEQ_MOVI;
    if (base == OP_LD) return SEQ_LD;
    if (base == OP_ST) return SEQ_ST;
    case (op)
      OP_ADD:  return SEQ_ADD;
      OP_SUB:  return SEQ_SUB;
      OP_JNZ:  return SEQ_JNZ;
      OP_STI:  return SEQ_STI;
      OP_CLI:  return SEQ_CLI;
      OP_HLT:  return SEQ_HLT;
      default: return SEQ_NOP;
    endcase
  endfunction

  assign start         = start_addr(fi.opcode);
  assign fi.need_imm   = (start == SEQ_MOVI) || (start == SEQ_LD) || (start == SEQ_ST);
  assign fi.need_byte2 = (start == SEQ_ADD) || (start == SEQ_SUB) || (start == SEQ_JNZ);
  assign fi.ready      = !live_q;
  assign accept        = fi.valid && fi.ready;

  always_ff @(posedge clk) begin
    if (rst) begin
      live_q <= 1'b0;
      addr_q <= SEQ_NOP;
    end else if (accept) begin
      live_q <= 1'b1;
      addr_q <= start;
    end else if (live_q && ex_done_i) begin
      if (word_i.end_seq)
        live_q <= 1'b0;
      else
        addr_q <= addr_q + MICRO_ADDR_W'(word_i.next);
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      imm_q   <= fi.imm;
      modrm_q <= fi.modrm;
      reg_q   <= fi.opcode[REG_W-1:0];
    end
  end

  assign seq_addr_o = addr_q;
  assign ex_valid_o = live_q;
  assign boundary_o = !live_q;
  assign imm_o      = imm_q;
  assign modrm_o    = modrm_q;
  assign reg_o      = reg_q;

endmodule

//--- hw/micro_rom.sv
// combinational microcode table, one control word per address
// all current sequences are one step long
`timescale 1ns/1ns

module micro_rom
  import core_pkg::*;
(
  input  logic [MICRO_ADDR_W-1:0] seq_addr_i,
  output micro_word_t             word_o
);

  // single closing step
  function automatic micro_word_t step(
    input micro_op_e  op,
    input logic [1:0] dst,
    input logic [1:0] src,
    input logic       use_imm,
    input logic       rd,
    input logic       wr
  );
    micro_word_t w;
    w.op      = op;
    w.dst_sel = dst;
    w.src_sel = src;
    w.use_imm = use_imm;
    w.mem_rd  = rd;
    w.mem_wr  = wr;
    w.end_seq = 1'b1;
    w.next    = 4'd0;
    return w;
  endfunction

  always_comb begin
    case (seq_addr_i)
      SEQ_MOVI: word_o = step(UOP_PASS, SEL_OPC, SEL_OPC, 1'b1, 1'b0, 1'b0);
      SEQ_ADD:  word_o = step(UOP_ADD, SEL_DST, SEL_SRC, 1'b0, 1'b0, 1'b0);
      SEQ_SUB:  word_o = step(UOP_SUB, SEL_DST, SEL_SRC, 1'b0, 1'b0, 1'b0);
      SEQ_LD:   word_o = step(UOP_LOAD, SEL_OPC, SEL_OPC, 1'b0, 1'b1, 1'b0);
      // store data comes from the opcode register
      SEQ_ST:   word_o = step(UOP_STORE, SEL_OPC, SEL_OPC, 1'b0, 1'b0, 1'b1);
      SEQ_JNZ:  word_o = step(UOP_JNZ, SEL_OPC, SEL_OPC, 1'b0, 1'b0, 1'b0);
      SEQ_STI:  word_o = step(UOP_STI, SEL_OPC, SEL_OPC, 1'b0, 1'b0, 1'b0);
      SEQ_CLI:  word_o = step(UOP_CLI, SEL_OPC, SEL_OPC, 1'b0, 1'b0, 1'b0);
      SEQ_HLT:  word_o = step(UOP_HLT, SEL_OPC, SEL_OPC, 1'b0, 1'b0, 1'b0);
      default:  word_o = step(UOP_NOP, SEL_OPC, SEL_OPC, 1'b0, 1'b0, 1'b0);
    endcase
  end

endmodule

//--- hw/core_exec.sv
// register file, ALU, zf and ifl, plus the LD/ST bus access
// data addresses are the 16-bit immediate, upper 4 address bits are zero
// pc_i must already point past the JNZ when its step runs
`timescale 1ns/1ns

module core_exec
  import core_pkg::*;
(
  input  logic             clk,
  input  logic             rst,
  input  logic             ex_valid_i,
  input  micro_word_t      word_i,
  input  logic [15:0]      imm_i,
  input  logic [7:0]       modrm_i,
  input  logic [REG_W-1:0] reg_i,
  input  logic             int_clr_i,
  output logic             ex_done_o,
  output logic             bus_req_o,
  output logic [19:0]      bus_addr_o,
  output logic             bus_we_o,
  output logic [15:0]      bus_wdata_o,
  input  logic             bus_ready_i,
  input  logic [15:0]      bus_rdata_i,
  input  logic [19:0]      pc_i,
  output logic             jump_o,
  output logic [19:0]      jump_target_o,
  output logic             ifl_o,
  output logic             halt_step_o
);

  logic [15:0]      regs_q [NREGS];
  flags_t           flags_q;
  logic [REG_W-1:0] dst_idx;
  logic [REG_W-1:0] src_idx;
  logic [15:0]      opa;
  logic [15:0]      opb;
  logic [15:0]      result;
  logic             wr_en;
  logic             set_zf;
  logic             mem_step;
  logic             fire;

  function automatic logic [REG_W-1:0] pick(
    input logic [1:0]       sel,
    input logic [REG_W-1:0] opc_reg,
    input logic [7:0]       modrm
  );
    case (sel)
      SEL_DST: return modrm[REG_W-1:0];
      SEL_SRC: return modrm[4 +: REG_W];
      default: return opc_reg;
    endcase
  endfunction

  assign dst_idx = pick(word_i.dst_sel, reg_i, modrm_i);
  assign src_idx = pick(word_i.src_sel, reg_i, modrm_i);
  assign opa     = regs_q[dst_idx];
  assign opb     = word_i.use_imm ? imm_i : regs_q[src_idx];

  always_comb begin
    result = opb;
    wr_en  = 1'b0;
    set_zf = 1'b0;
    case (word_i.op)
      UOP_PASS: wr_en = 1'b1;
      UOP_ADD: begin
        result = opa + opb;
        wr_en  = 1'b1;
        set_zf = 1'b1;
      end
      UOP_SUB: begin
        result = opa - opb;
        wr_en  = 1'b1;
        set_zf = 1'b1;
      end
      UOP_LOAD: begin
        result = bus_rdata_i;
        wr_en  = 1'b1;
      end
      default: ;
    endcase
  end

  // memory steps finish on the bus ready, all others at once
  assign mem_step    = word_i.mem_rd || word_i.mem_wr;
  assign bus_req_o   = ex_valid_i && mem_step;
  assign bus_addr_o  = {4'h0, imm_i};
  assign bus_we_o    = word_i.mem_wr;
  assign bus_wdata_o = opb;
  assign ex_done_o   = ex_valid_i && (!mem_step || bus_ready_i);
  assign fire        = ex_done_o;

  always_ff @(posedge clk) begin
    if (fire && wr_en)
      regs_q[dst_idx] <= result;
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      flags_q <= '0;
    end else begin
      if (fire && set_zf)
        flags_q.zf <= (result == 16'd0);
      // interrupt entry masks further interrupts
      if (int_clr_i)
        flags_q.ifl <= 1'b0;
      else if (fire && word_i.op == UOP_STI)
        flags_q.ifl <= 1'b1;
      else if (fire && word_i.op == UOP_CLI)
        flags_q.ifl <= 1'b0;
    end
  end

  assign jump_o        = ex_valid_i && (word_i.op == UOP_JNZ) && !flags_q.zf;
  assign jump_target_o = pc_i + {{12{modrm_i[7]}}, modrm_i};
  assign ifl_o         = flags_q.ifl;
  assign halt_step_o   = ex_valid_i && (word_i.op == UOP_HLT);

endmodule

//--- hw/core_top.sv
// core top level, one shared memory bus for fetch and data access
// exec owns the bus for LD/ST, and fetch also stays off it during JNZ and HLT
// HLT stops all bus traffic until intr_i arrives with ifl set
// inta_o is registered, one cycle after the interrupt is taken
`timescale 1ns/1ns

module core_top
  import core_pkg::*;
#(
  parameter logic [19:0] INT_VECTOR = 20'h00100
) (
  input  logic        clk,
  input  logic        rst,
  input  logic        intr_i,
  output logic        inta_o,
  output logic        mem_valid_o,
  input  logic        mem_ready_i,
  output logic [19:0] mem_addr_o,
  output logic        mem_we_o,
  output logic [15:0] mem_wdata_o,
  input  logic [15:0] mem_rdata_i,
  output logic [19:0] pc_o
);

  fetch_if fi ();

  micro_word_t             word;
  logic [MICRO_ADDR_W-1:0] seq_addr;
  logic [15:0]             imm;
  logic [7:0]              modrm;
  logic [REG_W-1:0]        reg_sel;
  logic                    ex_valid;
  logic                    ex_done;
  logic                    boundary;
  logic                    f_req;
  logic [19:0]             f_addr;
  logic                    ex_req;
  logic [19:0]             ex_addr;
  logic                    ex_we;
  logic                    jump;
  logic [19:0]             jump_target;
  logic                    ifl;
  logic                    halt_step;
  logic                    int_taken;
  logic                    exec_hold;
  logic                    halt_q;
  logic [19:0]             pc;

  // steps that use the bus or redirect fetch keep fetch idle
  assign exec_hold = ex_valid && (word.mem_rd || word.mem_wr ||
                                  word.op == UOP_JNZ || word.op == UOP_HLT);

  core_fetch #(
    .INT_VECTOR (INT_VECTOR)
  ) u_fetch (
    .clk           (clk),
    .rst           (rst),
    .fi            (fi.fetch),
    .bus_req_o     (f_req),
    .bus_addr_o    (f_addr),
    .bus_ready_i   (mem_ready_i),
    .bus_byte_i    (mem_rdata_i[7:0]),
    .bus_blocked_i (exec_hold || halt_q),
    .jump_i        (jump),
    .jump_target_i (jump_target),
    .intr_i        (intr_i),
    .ifl_i         (ifl),
    .boundary_i    (boundary),
    .int_taken_o   (int_taken),
    .pc_o          (pc)
  );

  core_decode u_decode (
    .clk        (clk),
    .rst        (rst),
    .fi         (fi.decode),
    .ex_done_i  (ex_done),
    .word_i     (word),
    .seq_addr_o (seq_addr),
    .ex_valid_o (ex_valid),
    .imm_o      (imm),
    .modrm_o    (modrm),
    .reg_o      (reg_sel),
    .boundary_o (boundary)
  );

  micro_rom u_rom (
    .seq_addr_i (seq_addr),
    .word_o     (word)
  );

  core_exec u_exec (
    .clk           (clk),
    .rst           (rst),
    .ex_valid_i    (ex_valid),
    .word_i        (word),
    .imm_i         (imm),
    .modrm_i       (modrm),
    .reg_i         (reg_sel),
    .int_clr_i     (int_taken),
    .ex_done_o     (ex_done),
    .bus_req_o     (ex_req),
    .bus_addr_o    (ex_addr),
    .bus_we_o      (ex_we),
    .bus_wdata_o   (mem_wdata_o),
    .bus_ready_i   (mem_ready_i),
    .bus_rdata_i   (mem_rdata_i),
    .pc_i          (pc),
    .jump_o        (jump),
    .jump_target_o (jump_target),
    .ifl_o         (ifl),
    .halt_step_o   (halt_step)
  );

  // exec wins, fetch never requests alongside it
  assign mem_valid_o = ex_req || f_req;
  assign mem_addr_o  = ex_req ? ex_addr : f_addr;
  assign mem_we_o    = ex_req && ex_we;
  assign pc_o        = pc;

  always_ff @(posedge clk) begin
    if (rst) begin
      halt_q <= 1'b0;
      inta_o <= 1'b0;
    end else begin
      inta_o <= int_taken;
      if (intr_i && ifl)
        halt_q <= 1'b0;
      else if (halt_step && ex_done)
        halt_q <= 1'b1;
    end
  end

endmodule

//--- bench/core_assertions.sv
// bus protocol, reset, halt and inta checks, bound into core_top
// fail_cnt counts assertion failures for the testbench summary
`timescale 1ns/1ns

module core_assertions (
  input logic        clk,
  input logic        rst,
  input logic        intr_i,
  input logic        inta_o,
  input logic        mem_valid_o,
  input logic        mem_ready_i,
  input logic [19:0] mem_addr_o,
  input logic        mem_we_o,
  input logic [15:0] mem_wdata_o,
  input logic        halt_q,
  input logic        ifl
);

  int fail_cnt = 0;

  // request fields hold until the memory takes them
  a_req_hold: assert property (@(posedge clk) disable iff (rst)
    mem_valid_o && !mem_ready_i |=> mem_valid_o && $stable(mem_addr_o) &&
      $stable(mem_we_o) && (!mem_we_o || $stable(mem_wdata_o)))
    else begin
      $error("bus request dropped or changed before ready");
      fail_cnt++;
    end

  // reset state shows one edge after rst is seen
  a_reset_quiet: assert property (@(posedge clk)
    rst |=> !mem_valid_o && !mem_we_o && !inta_o)
    else begin
      $error("bus request or inta during reset");
      fail_cnt++;
    end

  a_halt_quiet: assert property (@(posedge clk) disable iff (rst)
    halt_q |-> !mem_valid_o)
    else begin
      $error("bus request while halted");
      fail_cnt++;
    end

  // only an enabled interrupt leaves halt
  a_halt_hold: assert property (@(posedge clk) disable iff (rst)
    halt_q && !(intr_i && ifl) |=> halt_q)
    else begin
      $error("halt left without an enabled interrupt");
      fail_cnt++;
    end

  a_inta_pulse: assert property (@(posedge clk) disable iff (rst)
    inta_o |=> !inta_o)
    else begin
      $error("inta wider than one cycle");
      fail_cnt++;
    end

  a_inta_cause: assert property (@(posedge clk) disable iff (rst)
    inta_o |-> $past(intr_i && ifl))
    else begin
      $error("inta without an enabled interrupt request");
      fail_cnt++;
    end

endmodule

bind core_top core_assertions u_chk (
  .clk         (clk),
  .rst         (rst),
  .intr_i      (intr_i),
  .inta_o      (inta_o),
  .mem_valid_o (mem_valid_o),
  .mem_ready_i (mem_ready_i),
  .mem_addr_o  (mem_addr_o),
  .mem_we_o    (mem_we_o),
  .mem_wdata_o (mem_wdata_o),
  .halt_q      (halt_q),
  .ifl         (ifl)
);

//--- bench/tb_core.sv
// testbench for core_top with a program memory model
// one 16-bit word per address, fetch takes the low byte, 1024 words
// ready follows 0 to 3 random wait cycles
`timescale 1ns/1ns

module tb_core
  import core_pkg::*;
;

  localparam logic [19:0] INT_VECTOR = 20'h00100;
  // about 120 bus transfers at up to 4 cycles, plus exec steps and the halt wait
  localparam int LIMIT_CYCLES = 2000;

  localparam logic [15:0] A0          = 16'h1234;
  localparam logic [15:0] A1          = 16'h0F0F;
  localparam logic [15:0] A2          = 16'h0005;
  localparam logic [15:0] LD_SEED     = 16'h7A5C;
  localparam logic [15:0] HANDLER_VAL = 16'hBEEF;
  localparam logic [15:0] FINAL_VAL   = 16'h0C1E;
  localparam int          LOOP_N      = 4;

  logic        clk = 1'b0;
  logic        rst;
  logic        intr_i;
  logic        inta_o;
  logic        mem_valid_o;
  logic        mem_ready_i;
  logic [19:0] mem_addr_o;
  logic        mem_we_o;
  logic [15:0] mem_wdata_o;
  logic [15:0] mem_rdata_i;
  logic [19:0] pc_o;

  logic [15:0] mem [0:1023];
  int          wr_cnt [0:1023];
  int          loc;
  int          halt_pc;
  int          seed = 32'h29a3;
  int          rnd;
  int          wait_left;
  bit          pending;
  int          cycles;
  int          inta_cnt;
  int          n_pass;
  int          n_fail;

  core_top #(
    .INT_VECTOR (INT_VECTOR)
  ) dut0 (
    .clk         (clk),
    .rst         (rst),
    .intr_i      (intr_i),
    .inta_o      (inta_o),
    .mem_valid_o (mem_valid_o),
    .mem_ready_i (mem_ready_i),
    .mem_addr_o  (mem_addr_o),
    .mem_we_o    (mem_we_o),
    .mem_wdata_o (mem_wdata_o),
    .mem_rdata_i (mem_rdata_i),
    .pc_o        (pc_o)
  );

  always #2 clk = ~clk;

  // ready is decided on the falling edge and the transfer lands on the next rising edge
  always @(negedge clk) begin
    mem_ready_i = 1'b0;
    if (rst || !mem_valid_o) begin
      pending = 1'b0;
    end else begin
      if (!pending) begin
        pending   = 1'b1;
        rnd       = $random(seed);
        wait_left = rnd & 3;
      end
      if (wait_left == 0) begin
        pending     = 1'b0;
        mem_ready_i = 1'b1;
        if (mem_we_o) begin
          mem[mem_addr_o[9:0]]    = mem_wdata_o;
          wr_cnt[mem_addr_o[9:0]] = wr_cnt[mem_addr_o[9:0]] + 1;
        end else begin
          mem_rdata_i = mem[mem_addr_o[9:0]];
        end
      end else begin
        wait_left--;
      end
    end
  end

  always @(negedge clk) begin
    if (!rst && inta_o)
      inta_cnt++;
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles >= LIMIT_CYCLES) begin
      $display("timeout after %0d cycles, the program did not finish", cycles);
      $display("ERRORS FOUND");
      $finish;
    end
  end

  task automatic emit(input logic [7:0] b);
    mem[loc] = {8'h00, b};
    loc++;
  endtask

  task automatic movi(input int r, input logic [15:0] v);
    emit(8'(OP_MOVI) + 8'(r));
    emit(v[7:0]);
    emit(v[15:8]);
  endtask

  // modrm byte has dst in bits 3..0, src in bits 7..4
  task automatic alu(input logic [7:0] op, input int dst, input int src);
    emit(op);
    emit({4'(src), 4'(dst)});
  endtask

  task automatic ldst(input logic [7:0] op, input int r, input logic [15:0] addr);
    emit(op + 8'(r));
    emit(addr[7:0]);
    emit(addr[15:8]);
  endtask

  // offset counts from the byte after the JNZ
  task automatic jnz(input int target);
    int offset;
    offset = target - (loc + 2);
    emit(OP_JNZ);
    emit(8'(offset));
  endtask

  task automatic build_program();
    int top;
    for (int i = 0; i < 1024; i++) begin
      mem[i]    = 16'(i) ^ 16'h5A5A;
      wr_cnt[i] = 0;
    end
    mem[10'h210] = LD_SEED;
    loc = 0;
    movi(0, A0);
    movi(1, A1);
    alu(OP_ADD, 0, 1);
    ldst(OP_ST, 0, 16'h0200);
    movi(2, A2);
    alu(OP_SUB, 1, 2);
    ldst(OP_ST, 1, 16'h0201);
    ldst(OP_LD, 3, 16'h0210);
    alu(OP_ADD, 3, 0);
    ldst(OP_ST, 3, 16'h0202);
    // countdown in r0 and iteration count in r2
    movi(0, 16'(LOOP_N));
    movi(1, 16'h0001);
    movi(2, 16'h0000);
    top = loc;
    alu(OP_ADD, 2, 1);
    ldst(OP_ST, 2, 16'h0203);
    alu(OP_SUB, 0, 1);
    jnz(top);
    emit(OP_STI);
    emit(OP_HLT);
    // fetch stops right after the halt byte
    halt_pc = loc;
    // handler with markers at 0x204 and 0x205 around STI/CLI
    loc = int'(INT_VECTOR);
    movi(3, HANDLER_VAL);
    ldst(OP_ST, 3, 16'h0204);
    emit(OP_STI);
    emit(OP_CLI);
    ldst(OP_ST, 3, 16'h0205);
    movi(0, 16'h0003);
    movi(2, 16'h0001);
    top = loc;
    alu(OP_SUB, 0, 2);
    jnz(top);
    movi(1, FINAL_VAL);
    ldst(OP_ST, 1, 16'h0206);
    emit(OP_HLT);
  endtask

  task automatic check_word(input string name, input logic [19:0] exp,
                            input logic [19:0] act, inout bit ok);
    assert (act === exp) else begin
      $display("** Error %s: expected %h, actual %h", name, exp, act);
      ok = 1'b0;
    end
  endtask

  task automatic end_test(input string name, input bit ok);
    if (ok) begin
      n_pass++;
      $display("test %s: passed", name);
    end else begin
      n_fail++;
      $display("test %s: failed", name);
    end
  endtask

  task automatic wait_stores(input int addr, input int n);
    while (wr_cnt[addr] < n)
      @(posedge clk);
  endtask

  task automatic wait_halt();
    @(negedge clk);
    while (!dut0.halt_q)
      @(negedge clk);
  endtask

  task automatic pulse_intr();
    @(negedge clk);
    intr_i = 1'b1;
    @(negedge clk);
    intr_i = 1'b0;
  endtask

  initial begin
    bit          ok;
    logic [15:0] sum;
    rst         = 1'b1;
    intr_i      = 1'b0;
    mem_ready_i = 1'b0;
    mem_rdata_i = 16'h0000;
    cycles      = 0;
    inta_cnt    = 0;
    n_pass      = 0;
    n_fail      = 0;
    build_program();
    repeat (4) @(negedge clk);
    ok = 1'b1;
    check_word("reset pc", 20'h00000, pc_o, ok);
    end_test("reset state", ok);
    rst = 1'b0;

    sum = A0 + A1;
    wait_stores(10'h201, 1);
    ok = 1'b1;
    check_word("arith add", sum, mem[10'h200], ok);
    check_word("arith sub", A1 - A2, mem[10'h201], ok);
    end_test("arith", ok);

    wait_stores(10'h202, 1);
    ok = 1'b1;
    check_word("load store", LD_SEED + sum, mem[10'h202], ok);
    end_test("load store", ok);

    wait_halt();
    ok = 1'b1;
    check_word("loop counter", 16'(LOOP_N), mem[10'h203], ok);
    check_word("loop stores", 16'(LOOP_N), 16'(wr_cnt[10'h203]), ok);
    check_word("halt pc", 20'(halt_pc), pc_o, ok);
    end_test("jnz loop", ok);

    // stay halted a while so the bus stays quiet before the interrupt
    repeat (8) @(negedge clk);
    pulse_intr();
    wait_stores(10'h204, 1);
    ok = 1'b1;
    check_word("handler store", HANDLER_VAL, mem[10'h204], ok);
    check_word("inta count", 16'd1, 16'(inta_cnt), ok);
    end_test("halt interrupt", ok);

    wait_stores(10'h205, 1);
    pulse_intr();
    wait_stores(10'h206, 1);
    ok = 1'b1;
    check_word("final store", FINAL_VAL, mem[10'h206], ok);
    check_word("masked inta count", 16'd1, 16'(inta_cnt), ok);
    end_test("masked interrupt", ok);

    repeat (4) @(negedge clk);
    ok = (dut0.u_chk.fail_cnt == 0);
    if (!ok)
      $display("bus, reset, halt or inta assertions failed %0d times", dut0.u_chk.fail_cnt);
    end_test("bus and interrupt protocol", ok);

    $display("%0d tests passed, %0d tests failed", n_pass, n_fail);
    if (n_fail == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

//--- all.f
hw/core_pkg.sv
hw/fetch_if.sv
hw/core_fetch.sv
hw/core_decode.sv
hw/micro_rom.sv
hw/core_exec.sv
hw/core_top.sv
bench/core_assertions.sv
bench/tb_core.sv
